// ==== design/wb_bus_pkg.sv ====
// Wishbone bus definitions
// Data, byte-select and address widths of the shared 32-bit bus,
// plus the slave numbering and the address bits that select a slave

package wb_bus_pkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int WB_DWIDTH = 32;
    localparam int WB_SWIDTH = 4;
    localparam int WB_AWIDTH = 32;

    typedef logic [WB_DWIDTH-1:0] wb_data_t;
    typedef logic [WB_SWIDTH-1:0] wb_sel_t;
    typedef logic [WB_AWIDTH-1:0] wb_addr_t;

    // --------------------
    // Address map
    // --------------------
    localparam int NUM_SLAVES = 3;

    // Slave index equals the value of the region bits
    localparam int SLAVE_BOOT_MEM = 0;
    localparam int SLAVE_TIMER    = 1;
    localparam int SLAVE_IRQ_CTRL = 2;

    // Region bits of the byte address
    localparam int SLAVE_SEL_MSB = 31;
    localparam int SLAVE_SEL_LSB = 28;

endpackage

// ==== design/soc_regs_pkg.sv ====
// Peripheral register map
// Register offsets of the timer and the interrupt controller,
// timer control bits and the numbering of interrupt sources

package soc_regs_pkg;

    // Offset of a register inside its slave region
    localparam int REG_OFFSET_W = 4;
    typedef logic [REG_OFFSET_W-1:0] reg_offset_t;

    // --------------------
    // Interrupt sources
    // --------------------
    localparam int NUM_IRQ_SRC   = 4;
    // Source 0 is the timer, the external pins sit above it
    localparam int IRQ_SRC_TIMER = 0;

    // --------------------
    // Timer
    // --------------------
    localparam reg_offset_t TIMER_LOAD  = 4'h0;
    localparam reg_offset_t TIMER_VALUE = 4'h4;
    localparam reg_offset_t TIMER_CTRL  = 4'h8;
    localparam reg_offset_t TIMER_CLEAR = 4'hc;

    localparam int TIMER_CTRL_BITS     = 2;
    localparam int TIMER_CTRL_ENABLE   = 0;
    localparam int TIMER_CTRL_PERIODIC = 1;

    // --------------------
    // Interrupt controller
    // --------------------
    localparam reg_offset_t IRQ_RAW_STATUS   = 4'h0;
    localparam reg_offset_t IRQ_ENABLE_SET   = 4'h4;
    localparam reg_offset_t IRQ_ENABLE_CLEAR = 4'h8;
    localparam reg_offset_t IRQ_STATUS       = 4'hc;

endpackage

// ==== design/wishbone_arbiter.sv ====
// Wishbone arbiter for two masters and three slaves
// Master 0 wins when both masters request in the same cycle
// The grant is registered and held until the owner drops cyc
// Address bits 31:28 select the slave, unmapped regions answer with err

`timescale 1ns/10ps

module wishbone_arbiter (
    input  logic                                i_clk,
    input  logic                                i_rst,

    // Master 0
    input  wb_bus_pkg::wb_addr_t                i_m0_wb_adr,
    input  wb_bus_pkg::wb_sel_t                 i_m0_wb_sel,
    input  logic                                i_m0_wb_we,
    input  wb_bus_pkg::wb_data_t                i_m0_wb_dat,
    input  logic                                i_m0_wb_cyc,
    input  logic                                i_m0_wb_stb,
    output wb_bus_pkg::wb_data_t                o_m0_wb_dat,
    output logic                                o_m0_wb_ack,
    output logic                                o_m0_wb_err,

    // Master 1
    input  wb_bus_pkg::wb_addr_t                i_m1_wb_adr,
    input  wb_bus_pkg::wb_sel_t                 i_m1_wb_sel,
    input  logic                                i_m1_wb_we,
    input  wb_bus_pkg::wb_data_t                i_m1_wb_dat,
    input  logic                                i_m1_wb_cyc,
    input  logic                                i_m1_wb_stb,
    output wb_bus_pkg::wb_data_t                o_m1_wb_dat,
    output logic                                o_m1_wb_ack,
    output logic                                o_m1_wb_err,

    // Slave side, shared request fields and one stb per slave
    output wb_bus_pkg::wb_addr_t                o_s_wb_adr,
    output wb_bus_pkg::wb_sel_t                 o_s_wb_sel,
    output logic                                o_s_wb_we,
    output wb_bus_pkg::wb_data_t                o_s_wb_dat,
    output logic [wb_bus_pkg::NUM_SLAVES-1:0]   o_s_wb_stb,
    input  wb_bus_pkg::wb_data_t                i_s0_wb_dat,
    input  wb_bus_pkg::wb_data_t                i_s1_wb_dat,
    input  wb_bus_pkg::wb_data_t                i_s2_wb_dat,
    input  logic [wb_bus_pkg::NUM_SLAVES-1:0]   i_s_wb_ack
);
    import wb_bus_pkg::*;

    logic                                   grant_valid;
    // Low selects master 0
    logic                                   grant_sel;
    logic                                   m0_req;
    logic                                   m1_req;
    wb_addr_t                               m_adr;
    wb_sel_t                                m_sel;
    logic                                   m_we;
    wb_data_t                               m_dat;
    logic                                   m_cyc;
    logic                                   m_stb;
    logic [SLAVE_SEL_MSB-SLAVE_SEL_LSB:0]   region;
    logic [NUM_SLAVES-1:0]                  slave_hit;
    logic                                   mapped;
    logic                                   s_ack;
    wb_data_t                               s_dat;
    logic                                   err_q;

    assign m0_req = i_m0_wb_cyc && i_m0_wb_stb;
    assign m1_req = i_m1_wb_cyc && i_m1_wb_stb;

    // --------------------
    // Grant
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            grant_valid <= 1'b0;
            grant_sel   <= 1'b0;
        end else if (!grant_valid) begin
            if (m0_req || m1_req) begin
                grant_valid <= 1'b1;
                grant_sel   <= !m0_req;
            end
        end else if (!m_cyc) begin
            grant_valid <= 1'b0;
        end
    end

    // Granted master onto the shared request
    always_comb begin
        if (grant_sel) begin
            m_adr = i_m1_wb_adr;
            m_sel = i_m1_wb_sel;
            m_we  = i_m1_wb_we;
            m_dat = i_m1_wb_dat;
            m_cyc = i_m1_wb_cyc;
            m_stb = i_m1_wb_cyc && i_m1_wb_stb;
        end else begin
            m_adr = i_m0_wb_adr;
            m_sel = i_m0_wb_sel;
            m_we  = i_m0_wb_we;
            m_dat = i_m0_wb_dat;
            m_cyc = i_m0_wb_cyc;
            m_stb = i_m0_wb_cyc && i_m0_wb_stb;
        end
    end

    // --------------------
    // Address decode
    // --------------------
    assign region = m_adr[SLAVE_SEL_MSB:SLAVE_SEL_LSB];

    always_comb begin
        slave_hit = '0;
        s_dat     = '0;
        case (region)
            SLAVE_BOOT_MEM: begin
                slave_hit[SLAVE_BOOT_MEM] = 1'b1;
                s_dat                     = i_s0_wb_dat;
            end
            SLAVE_TIMER: begin
                slave_hit[SLAVE_TIMER] = 1'b1;
                s_dat                  = i_s1_wb_dat;
            end
            SLAVE_IRQ_CTRL: begin
                slave_hit[SLAVE_IRQ_CTRL] = 1'b1;
                s_dat                     = i_s2_wb_dat;
            end
            default: slave_hit = '0;
        endcase
    end

    assign mapped     = |slave_hit;
    assign s_ack      = |(i_s_wb_ack & slave_hit);

    assign o_s_wb_adr = m_adr;
    assign o_s_wb_sel = m_sel;
    assign o_s_wb_we  = m_we;
    assign o_s_wb_dat = m_dat;
    assign o_s_wb_stb = (grant_valid && m_stb) ? slave_hit : '0;

    // One-cycle err pulse for an unmapped region
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= grant_valid && m_stb && !mapped && !err_q;
        end
    end

    // Responses go back only to the granted master
    assign o_m0_wb_dat = s_dat;
    assign o_m1_wb_dat = s_dat;
    assign o_m0_wb_ack = grant_valid && !grant_sel && s_ack;
    assign o_m1_wb_ack = grant_valid &&  grant_sel && s_ack;
    assign o_m0_wb_err = !grant_sel && err_q;
    assign o_m1_wb_err =  grant_sel && err_q;

endmodule

// ==== design/boot_mem.sv ====
// On-chip boot memory
// Single-port word array on the Wishbone bus with per-byte write enables
// Reads return the full word together with the registered ack

`timescale 1ns/10ps

module boot_mem #(
    parameter int MEM_WORDS = 2048
) (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  wb_bus_pkg::wb_addr_t    i_wb_adr,
    input  wb_bus_pkg::wb_sel_t     i_wb_sel,
    input  logic                    i_wb_we,
    input  wb_bus_pkg::wb_data_t    i_wb_dat,
    input  logic                    i_wb_stb,
    output wb_bus_pkg::wb_data_t    o_wb_dat,
    output logic                    o_wb_ack
);
    import wb_bus_pkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);

    wb_data_t           mem [MEM_WORDS];
    logic [ADDR_W-1:0]  word_idx;
    logic               wb_start;

    // Word address where the upper bits alias
    assign word_idx = i_wb_adr[ADDR_W+1:2];
    assign wb_start = i_wb_stb && !o_wb_ack;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= wb_start;
        end
    end

    // Byte-masked write and word read
    always_ff @(posedge i_clk) begin
        if (wb_start && i_wb_we) begin
            for (int b = 0; b < WB_SWIDTH; b++) begin
                if (i_wb_sel[b]) begin
                    mem[word_idx][b*8 +: 8] <= i_wb_dat[b*8 +: 8];
                end
            end
        end
        if (wb_start && !i_wb_we) begin
            o_wb_dat <= mem[word_idx];
        end
    end

endmodule

// ==== design/timer_module.sv ====
// Single-channel count-down timer
// Counts from the load value once per cycle while enabled
// At zero it raises the interrupt, then reloads or stops
// A write to the clear register drops the interrupt

`timescale 1ns/10ps

module timer_module #(
    parameter int TIMER_WIDTH = 16
) (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  wb_bus_pkg::wb_addr_t    i_wb_adr,
    input  logic                    i_wb_we,
    input  wb_bus_pkg::wb_data_t    i_wb_dat,
    input  logic                    i_wb_stb,
    output wb_bus_pkg::wb_data_t    o_wb_dat,
    output logic                    o_wb_ack,
    output logic                    o_timer_int
);
    import wb_bus_pkg::*;
    import soc_regs_pkg::*;

    logic [TIMER_WIDTH-1:0]     load_q;
    logic [TIMER_WIDTH-1:0]     count_q;
    logic [TIMER_CTRL_BITS-1:0] ctrl_q;
    reg_offset_t                offset;
    logic                       wb_start;
    logic                       wr_en;
    logic                       zero_hit;

    assign offset   = i_wb_adr[REG_OFFSET_W-1:0];
    assign wb_start = i_wb_stb && !o_wb_ack;
    assign wr_en    = wb_start && i_wb_we;
    assign zero_hit = ctrl_q[TIMER_CTRL_ENABLE] && (count_q == '0);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= wb_start;
        end
    end

    // --------------------
    // Counter and control
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            count_q     <= '0;
            ctrl_q      <= '0;
            o_timer_int <= 1'b0;
        end else begin
            if (zero_hit) begin
                o_timer_int <= 1'b1;
                if (ctrl_q[TIMER_CTRL_PERIODIC]) begin
                    count_q <= load_q;
                end else begin
                    // One-shot mode stops here
                    ctrl_q[TIMER_CTRL_ENABLE] <= 1'b0;
                end
            end else if (ctrl_q[TIMER_CTRL_ENABLE]) begin
                count_q <= count_q - 1'b1;
            end

            // Bus writes take priority over counting
            if (wr_en && offset == TIMER_LOAD) begin
                count_q <= i_wb_dat[TIMER_WIDTH-1:0];
            end
            if (wr_en && offset == TIMER_CTRL) begin
                ctrl_q <= i_wb_dat[TIMER_CTRL_BITS-1:0];
            end
            if (wr_en && offset == TIMER_CLEAR) begin
                o_timer_int <= 1'b0;
            end
        end
    end

    // Load value and read data
    always_ff @(posedge i_clk) begin
        if (wr_en && offset == TIMER_LOAD) begin
            load_q <= i_wb_dat[TIMER_WIDTH-1:0];
        end
        if (wb_start) begin
            case (offset)
                TIMER_LOAD:  o_wb_dat <= wb_data_t'(load_q);
                TIMER_VALUE: o_wb_dat <= wb_data_t'(count_q);
                TIMER_CTRL:  o_wb_dat <= wb_data_t'(ctrl_q);
                TIMER_CLEAR: o_wb_dat <= wb_data_t'(o_timer_int);
                default:     o_wb_dat <= '0;
            endcase
        end
    end

endmodule

// ==== design/interrupt_controller.sv ====
// Interrupt controller
// Samples the sources every cycle and keeps a set/clear enable mask
// The combined interrupt is the OR of the masked status

`timescale 1ns/10ps

module interrupt_controller (
    input  logic                                i_clk,
    input  logic                                i_rst,
    input  wb_bus_pkg::wb_addr_t                i_wb_adr,
    input  logic                                i_wb_we,
    input  wb_bus_pkg::wb_data_t                i_wb_dat,
    input  logic                                i_wb_stb,
    input  logic [soc_regs_pkg::NUM_IRQ_SRC-1:0] i_irq_src,
    output wb_bus_pkg::wb_data_t                o_wb_dat,
    output logic                                o_wb_ack,
    output logic                                o_irq
);
    import wb_bus_pkg::*;
    import soc_regs_pkg::*;

    logic [NUM_IRQ_SRC-1:0] raw_q;
    logic [NUM_IRQ_SRC-1:0] enable_q;
    logic [NUM_IRQ_SRC-1:0] status;
    reg_offset_t            offset;
    logic                   wb_start;
    logic                   wr_en;

    assign offset   = i_wb_adr[REG_OFFSET_W-1:0];
    assign wb_start = i_wb_stb && !o_wb_ack;
    assign wr_en    = wb_start && i_wb_we;
    assign status   = raw_q & enable_q;
    assign o_irq    = |status;

    // --------------------
    // Sources and mask
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            raw_q    <= '0;
            enable_q <= '0;
            o_wb_ack <= 1'b0;
        end else begin
            raw_q    <= i_irq_src;
            o_wb_ack <= wb_start;
            if (wr_en && offset == IRQ_ENABLE_SET) begin
                enable_q <= enable_q | i_wb_dat[NUM_IRQ_SRC-1:0];
            end else if (wr_en && offset == IRQ_ENABLE_CLEAR) begin
                enable_q <= enable_q & ~i_wb_dat[NUM_IRQ_SRC-1:0];
            end
        end
    end

    // Both enable offsets read back the mask
    always_ff @(posedge i_clk) begin
        if (wb_start) begin
            case (offset)
                IRQ_RAW_STATUS:   o_wb_dat <= wb_data_t'(raw_q);
                IRQ_ENABLE_SET:   o_wb_dat <= wb_data_t'(enable_q);
                IRQ_ENABLE_CLEAR: o_wb_dat <= wb_data_t'(enable_q);
                IRQ_STATUS:       o_wb_dat <= wb_data_t'(status);
                default:          o_wb_dat <= '0;
            endcase
        end
    end

endmodule

// ==== design/system.sv ====
// System top level
// Two Wishbone master ports feed the arbiter, which serves the boot
// memory, the timer and the interrupt controller
// The timer interrupt joins three external lines as interrupt sources

`timescale 1ns/10ps

module system #(
    parameter int MEM_WORDS   = 2048,
    parameter int TIMER_WIDTH = 16
) (
    input  logic                                    i_clk,
    input  logic                                    i_rst,

    // Master 0
    input  wb_bus_pkg::wb_addr_t                    i_m0_wb_adr,
    input  wb_bus_pkg::wb_sel_t                     i_m0_wb_sel,
    input  logic                                    i_m0_wb_we,
    input  wb_bus_pkg::wb_data_t                    i_m0_wb_dat,
    input  logic                                    i_m0_wb_cyc,
    input  logic                                    i_m0_wb_stb,
    output wb_bus_pkg::wb_data_t                    o_m0_wb_dat,
    output logic                                    o_m0_wb_ack,
    output logic                                    o_m0_wb_err,

    // Master 1
    input  wb_bus_pkg::wb_addr_t                    i_m1_wb_adr,
    input  wb_bus_pkg::wb_sel_t                     i_m1_wb_sel,
    input  logic                                    i_m1_wb_we,
    input  wb_bus_pkg::wb_data_t                    i_m1_wb_dat,
    input  logic                                    i_m1_wb_cyc,
    input  logic                                    i_m1_wb_stb,
    output wb_bus_pkg::wb_data_t                    o_m1_wb_dat,
    output logic                                    o_m1_wb_ack,
    output logic                                    o_m1_wb_err,

    // External interrupt lines
    input  logic [soc_regs_pkg::NUM_IRQ_SRC-2:0]    i_irq_src,
    output logic                                    o_irq
);
    import wb_bus_pkg::*;
    import soc_regs_pkg::*;

    wb_addr_t               s_adr;
    wb_sel_t                s_sel;
    logic                   s_we;
    wb_data_t               s_wdat;
    logic [NUM_SLAVES-1:0]  s_stb;
    logic [NUM_SLAVES-1:0]  s_ack;
    wb_data_t               mem_rdat;
    wb_data_t               timer_rdat;
    wb_data_t               irq_rdat;
    logic                   timer_int;
    logic [NUM_IRQ_SRC-1:0] irq_src;

    assign irq_src[IRQ_SRC_TIMER]                 = timer_int;
    assign irq_src[NUM_IRQ_SRC-1:IRQ_SRC_TIMER+1] = i_irq_src;

    // --------------------
    // Arbiter
    // --------------------
    wishbone_arbiter u_wishbone_arbiter (
        .i_clk       ( i_clk        ),
        .i_rst       ( i_rst        ),
        .i_m0_wb_adr ( i_m0_wb_adr  ),
        .i_m0_wb_sel ( i_m0_wb_sel  ),
        .i_m0_wb_we  ( i_m0_wb_we   ),
        .i_m0_wb_dat ( i_m0_wb_dat  ),
        .i_m0_wb_cyc ( i_m0_wb_cyc  ),
        .i_m0_wb_stb ( i_m0_wb_stb  ),
        .o_m0_wb_dat ( o_m0_wb_dat  ),
        .o_m0_wb_ack ( o_m0_wb_ack  ),
        .o_m0_wb_err ( o_m0_wb_err  ),
        .i_m1_wb_adr ( i_m1_wb_adr  ),
        .i_m1_wb_sel ( i_m1_wb_sel  ),
        .i_m1_wb_we  ( i_m1_wb_we   ),
        .i_m1_wb_dat ( i_m1_wb_dat  ),
        .i_m1_wb_cyc ( i_m1_wb_cyc  ),
        .i_m1_wb_stb ( i_m1_wb_stb  ),
        .o_m1_wb_dat ( o_m1_wb_dat  ),
        .o_m1_wb_ack ( o_m1_wb_ack  ),
        .o_m1_wb_err ( o_m1_wb_err  ),
        .o_s_wb_adr  ( s_adr        ),
        .o_s_wb_sel  ( s_sel        ),
        .o_s_wb_we   ( s_we         ),
        .o_s_wb_dat  ( s_wdat       ),
        .o_s_wb_stb  ( s_stb        ),
        .i_s0_wb_dat ( mem_rdat     ),
        .i_s1_wb_dat ( timer_rdat   ),
        .i_s2_wb_dat ( irq_rdat     ),
        .i_s_wb_ack  ( s_ack        )
    );

    // --------------------
    // Slaves
    // --------------------
    boot_mem #(
        .MEM_WORDS ( MEM_WORDS )
    ) u_boot_mem (
        .i_clk    ( i_clk                  ),
        .i_rst    ( i_rst                  ),
        .i_wb_adr ( s_adr                  ),
        .i_wb_sel ( s_sel                  ),
        .i_wb_we  ( s_we                   ),
        .i_wb_dat ( s_wdat                 ),
        .i_wb_stb ( s_stb[SLAVE_BOOT_MEM]  ),
        .o_wb_dat ( mem_rdat               ),
        .o_wb_ack ( s_ack[SLAVE_BOOT_MEM]  )
    );

    timer_module #(
        .TIMER_WIDTH ( TIMER_WIDTH )
    ) u_timer_module (
        .i_clk       ( i_clk               ),
        .i_rst       ( i_rst               ),
        .i_wb_adr    ( s_adr               ),
        .i_wb_we     ( s_we                ),
        .i_wb_dat    ( s_wdat              ),
        .i_wb_stb    ( s_stb[SLAVE_TIMER]  ),
        .o_wb_dat    ( timer_rdat          ),
        .o_wb_ack    ( s_ack[SLAVE_TIMER]  ),
        .o_timer_int ( timer_int           )
    );

    interrupt_controller u_interrupt_controller (
        .i_clk     ( i_clk                  ),
        .i_rst     ( i_rst                  ),
        .i_wb_adr  ( s_adr                  ),
        .i_wb_we   ( s_we                   ),
        .i_wb_dat  ( s_wdat                 ),
        .i_wb_stb  ( s_stb[SLAVE_IRQ_CTRL]  ),
        .i_irq_src ( irq_src                ),
        .o_wb_dat  ( irq_rdat               ),
        .o_wb_ack  ( s_ack[SLAVE_IRQ_CTRL]  ),
        .o_irq     ( o_irq                  )
    );

endmodule

// ==== bench/tb_bus_tasks.svh ====
// Wishbone master tasks for the system testbench
// One task runs a complete bus cycle on either master port and
// waits for ack or err with a timeout; a write wrapper updates the model

localparam int BUS_TIMEOUT = 50;

task automatic bus_cycle(input int m, input wb_addr_t adr, input wb_sel_t sel,
                         input logic we, input wb_data_t wdat, output wb_data_t rdat,
                         output logic got_ack, output logic got_err, output realtime t_end);
    int   waited;
    logic ack_seen;
    logic err_seen;
    waited   = 0;
    ack_seen = 1'b0;
    err_seen = 1'b0;
    rdat     = '0;
    @(posedge clk);
    if (m == 0) begin
        m0_adr <= adr;
        m0_sel <= sel;
        m0_we  <= we;
        m0_dat <= wdat;
        m0_cyc <= 1'b1;
        m0_stb <= 1'b1;
    end else begin
        m1_adr <= adr;
        m1_sel <= sel;
        m1_we  <= we;
        m1_dat <= wdat;
        m1_cyc <= 1'b1;
        m1_stb <= 1'b1;
    end
    // Values seen here are the ones stable before the edge
    while (!ack_seen && !err_seen && waited < BUS_TIMEOUT) begin
        @(posedge clk);
        waited++;
        ack_seen = (m == 0) ? m0_ack : m1_ack;
        err_seen = (m == 0) ? m0_err : m1_err;
        rdat     = (m == 0) ? m0_rdat : m1_rdat;
    end
    if (m == 0) begin
        m0_cyc <= 1'b0;
        m0_stb <= 1'b0;
    end else begin
        m1_cyc <= 1'b0;
        m1_stb <= 1'b0;
    end
    if (!ack_seen && !err_seen) begin
        $display("Master %0d got no response at address %h", m, adr);
        errors++;
    end
    got_ack = ack_seen;
    got_err = err_seen;
    t_end   = $realtime;
endtask

task automatic bus_write(input int m, input wb_addr_t adr, input wb_sel_t sel,
                         input wb_data_t wdat);
    wb_data_t rdat;
    logic     ack;
    logic     err;
    realtime  t;
    bus_cycle(m, adr, sel, 1'b1, wdat, rdat, ack, err, t);
    if (ack) begin
        model_write(adr, sel, wdat);
    end else begin
        $display("Write by master %0d at %h was not acknowledged", m, adr);
        errors++;
    end
endtask

// ==== bench/system_tb.sv ====
// Testbench for the Wishbone system
// Stands in for both bus masters, keeps a reference model of memory
// and interrupt registers, and checks every read against it

`timescale 1ns/10ps

module system_tb;
    import wb_bus_pkg::*;
    import soc_regs_pkg::*;

    localparam int       MEM_WORDS = 2048;
    localparam int       ADDR_W    = 11;
    localparam wb_addr_t TIMER_BASE = 32'h1000_0000;
    localparam wb_addr_t IRQ_BASE   = 32'h2000_0000;

    logic     clk = 1'b0;
    logic     rst;
    wb_addr_t m0_adr, m1_adr;
    wb_sel_t  m0_sel, m1_sel;
    logic     m0_we, m1_we, m0_cyc, m1_cyc, m0_stb, m1_stb;
    wb_data_t m0_dat, m1_dat, m0_rdat, m1_rdat;
    logic     m0_ack, m1_ack, m0_err, m1_err;
    logic [2:0] irq_pins;
    logic     o_irq;

    // Reference model state
    wb_data_t         shadow_mem [MEM_WORDS];
    logic [3:0]       irq_mask;
    wb_data_t         got_q [$];
    wb_data_t         exp_q [$];
    string            name_q [$];
    wb_data_t         cmp_got, cmp_exp;
    string            cmp_name;
    int               errors = 0;
    int               checks = 0;
    integer           seed = 32'h9114;
    wb_addr_t         addr_list [8];

    always #20 clk = ~clk;

    system dut (
        .i_clk(clk), .i_rst(rst),
        .i_m0_wb_adr(m0_adr), .i_m0_wb_sel(m0_sel), .i_m0_wb_we(m0_we),
        .i_m0_wb_dat(m0_dat), .i_m0_wb_cyc(m0_cyc), .i_m0_wb_stb(m0_stb),
        .o_m0_wb_dat(m0_rdat), .o_m0_wb_ack(m0_ack), .o_m0_wb_err(m0_err),
        .i_m1_wb_adr(m1_adr), .i_m1_wb_sel(m1_sel), .i_m1_wb_we(m1_we),
        .i_m1_wb_dat(m1_dat), .i_m1_wb_cyc(m1_cyc), .i_m1_wb_stb(m1_stb),
        .o_m1_wb_dat(m1_rdat), .o_m1_wb_ack(m1_ack), .o_m1_wb_err(m1_err),
        .i_irq_src(irq_pins), .o_irq(o_irq)
    );

    `include "tb_bus_tasks.svh"

    // --------------------
    // Reference model
    // --------------------
    function automatic wb_data_t merge_bytes(wb_data_t old, wb_data_t wdat, wb_sel_t sel);
        wb_data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[b*8 +: 8] = wdat[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // Expected read data with the timer source bit taken as low
    function automatic wb_data_t expected_read(wb_addr_t adr);
        logic [3:0] raw;
        raw = {irq_pins, 1'b0};
        if (adr[31:28] == 4'h0) begin
            return shadow_mem[adr[ADDR_W+1:2]];
        end
        if (adr[31:28] != 4'h2) begin
            return '0;
        end
        case (adr[3:0])
            IRQ_RAW_STATUS:   return {28'b0, raw};
            IRQ_STATUS:       return {28'b0, raw & irq_mask};
            default:          return {28'b0, irq_mask};
        endcase
    endfunction

    task automatic model_write(input wb_addr_t adr, input wb_sel_t sel, input wb_data_t wdat);
        if (adr[31:28] == 4'h0) begin
            shadow_mem[adr[ADDR_W+1:2]] = merge_bytes(shadow_mem[adr[ADDR_W+1:2]], wdat, sel);
        end else if (adr[31:28] == 4'h2 && adr[3:0] == IRQ_ENABLE_SET) begin
            irq_mask = irq_mask | wdat[3:0];
        end else if (adr[31:28] == 4'h2 && adr[3:0] == IRQ_ENABLE_CLEAR) begin
            irq_mask = irq_mask & ~wdat[3:0];
        end
    endtask

    task automatic check_read(input int m, input wb_addr_t adr);
        wb_data_t rdat;
        logic     ack;
        logic     err;
        realtime  t;
        bus_cycle(m, adr, 4'hf, 1'b0, '0, rdat, ack, err, t);
        if (!ack) begin
            $display("Read by master %0d at %h was not acknowledged", m, adr);
            errors++;
        end
        got_q.push_back(rdat);
        exp_q.push_back(expected_read(adr));
        name_q.push_back((m == 0) ? "o_m0_wb_dat" : "o_m1_wb_dat");
    endtask

    task automatic check_irq_pin();
        logic exp_irq;
        exp_irq = |({irq_pins, 1'b0} & irq_mask);
        if (o_irq !== exp_irq) begin
            $display("FAILED o_irq: got %h expected %h", o_irq, exp_irq);
            errors++;
        end
    endtask

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0) begin
            $display("FAILED %s: got %h expected 0", name, value);
            errors++;
        end
    endtask

    // Compare process for finished reads
    always @(posedge clk) begin
        while (got_q.size() > 0) begin
            cmp_got  = got_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_name = name_q.pop_front();
            checks++;
            if (cmp_got !== cmp_exp) begin
                $display("FAILED %s: got %h expected %h", cmp_name, cmp_got, cmp_exp);
                errors++;
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        wb_data_t   rd0, rd1, v1, v2;
        logic       ack0, ack1, err0, err1;
        realtime    t0, t1;
        wb_data_t   rnd;
        int         waited;
        rst <= 1'b1;
        m0_adr <= '0;
        m0_sel <= '0;
        m0_we  <= 1'b0;
        m0_dat <= '0;
        m0_cyc <= 1'b0;
        m0_stb <= 1'b0;
        m1_adr <= '0;
        m1_sel <= '0;
        m1_we  <= 1'b0;
        m1_dat <= '0;
        m1_cyc <= 1'b0;
        m1_stb <= 1'b0;
        irq_pins <= 3'b000;
        irq_mask = 4'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Idle outputs after reset
        expect_low("o_irq", o_irq);
        expect_low("o_m0_wb_ack", m0_ack);
        expect_low("o_m1_wb_ack", m1_ack);
        expect_low("o_m0_wb_err", m0_err);
        expect_low("o_m1_wb_err", m1_err);

        // Random full words, then random byte-select writes, then reads
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            addr_list[i] = {19'b0, rnd[ADDR_W-1:0], 2'b00};
            bus_write(i % 2, addr_list[i], 4'hf, $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            bus_write((i + 1) % 2, addr_list[i], rnd[3:0], $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            check_read(i % 2, addr_list[i]);
        end

        // Same-cycle requests with priority to master 0
        fork
            bus_cycle(0, addr_list[0], 4'hf, 1'b1, 32'hcafe_0000, rd0, ack0, err0, t0);
            bus_cycle(1, addr_list[1], 4'hf, 1'b1, 32'hbeef_1111, rd1, ack1, err1, t1);
        join
        if (!ack0 || !ack1 || t0 >= t1) begin
            $display("Master 0 was not served before master 1 in the same-cycle request");
            errors++;
        end
        model_write(addr_list[0], 4'hf, 32'hcafe_0000);
        model_write(addr_list[1], 4'hf, 32'hbeef_1111);
        check_read(1, addr_list[0]);
        check_read(0, addr_list[1]);

        // Unmapped region answers with err only
        bus_cycle(0, 32'h5000_0000, 4'hf, 1'b0, '0, rd0, ack0, err0, t0);
        if (!err0 || ack0) begin
            $display("Unmapped access at 50000000 did not end with err alone");
            errors++;
        end
        bus_cycle(1, 32'h5000_0010, 4'hf, 1'b1, 32'h1234_5678, rd1, ack1, err1, t1);
        if (!err1 || ack1) begin
            $display("Unmapped write by master 1 at 50000010 did not end with err alone");
            errors++;
        end
        check_read(0, addr_list[2]);

        // Interrupt mask and status
        @(posedge clk);
        irq_pins <= 3'b101;
        repeat (3) @(posedge clk);
        bus_write(0, IRQ_BASE + IRQ_ENABLE_SET, 4'hf, 32'h6);
        check_read(0, IRQ_BASE + IRQ_STATUS);
        repeat (3) @(posedge clk);
        check_irq_pin();
        bus_write(1, IRQ_BASE + IRQ_ENABLE_CLEAR, 4'hf, 32'h2);
        check_read(1, IRQ_BASE + IRQ_STATUS);
        repeat (3) @(posedge clk);
        check_irq_pin();
        bus_write(0, IRQ_BASE + IRQ_ENABLE_SET, 4'hf, 32'h8);
        check_read(0, IRQ_BASE + IRQ_STATUS);
        check_read(0, IRQ_BASE + IRQ_RAW_STATUS);
        repeat (3) @(posedge clk);
        check_irq_pin();
        bus_write(0, IRQ_BASE + IRQ_ENABLE_CLEAR, 4'hf, 32'hf);
        irq_pins <= 3'b000;
        repeat (3) @(posedge clk);
        check_irq_pin();

        // One-shot timer with its interrupt enabled
        bus_write(0, IRQ_BASE + IRQ_ENABLE_SET, 4'hf, 32'h1);
        bus_write(0, TIMER_BASE + TIMER_LOAD, 4'hf, 32'd40);
        bus_write(0, TIMER_BASE + TIMER_CTRL, 4'hf, 32'h1);
        bus_cycle(0, TIMER_BASE + TIMER_VALUE, 4'hf, 1'b0, '0, v1, ack0, err0, t0);
        bus_cycle(1, TIMER_BASE + TIMER_VALUE, 4'hf, 1'b0, '0, v2, ack1, err1, t1);
        if (!(v2 < v1)) begin
            $display("FAILED TIMER_VALUE: got %h after %h", v2, v1);
            errors++;
        end
        waited = 0;
        while (!o_irq && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        if (!o_irq) begin
            $display("o_irq did not rise after the timer expired");
            errors++;
        end
        bus_write(1, TIMER_BASE + TIMER_CLEAR, 4'hf, 32'h1);
        repeat (3) @(posedge clk);
        expect_low("o_irq", o_irq);

        repeat (3) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+bench
design/wb_bus_pkg.sv
design/soc_regs_pkg.sv
design/wishbone_arbiter.sv
design/boot_mem.sv
design/timer_module.sv
design/interrupt_controller.sv
design/system.sv
bench/system_tb.sv

// ==== Makefile ====
# Verilator build for the Wishbone system testbench

SIM = obj_dir/Vsystem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module system_tb -f filelist.f

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
